// ==== project.f ====
+incdir+verif
rtl/vreg_pkg.sv
rtl/vreg_wr_if.sv
rtl/vreg_wr_stage.sv
rtl/vreg_wr_mux.sv
rtl/vreg_pend_tracker.sv
rtl/vregfile.sv
rtl/vreg_wr_subsys.sv
verif/vreg_wr_subsys_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it, the exit status gives pass or fail
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f project.f --top-module vreg_wr_subsys_tb -o vreg_wr_subsys_sim
./obj_dir/vreg_wr_subsys_sim

// ==== verif/vreg_wr_ref.svh ====
// expected-value functions for the register file and pending scoreboard model
// needs VREG_W and the vreg_pkg types visible where it is included
`ifndef VREG_WR_REF_SVH
`define VREG_WR_REF_SVH

// enabled bytes come from the new value, the rest keep the old register value
function automatic logic [VREG_W-1:0] byte_merge(
    input logic [VREG_W-1:0]   old_val,
    input logic [VREG_W-1:0]   new_val,
    input logic [VREG_W/8-1:0] be
);
    logic [VREG_W-1:0] mask;
    mask = '0;
    for (int b = 0; b < VREG_W / 8; b++) begin
        mask[b*8 +: 8] = {8{be[b]}};
    end
    return (old_val & ~mask) | (new_val & mask);
endfunction

// single mode clears one register, bulk mode an aligned group of 2**cnt registers
function automatic vreg_pend_t clear_vec(
    input vreg_addr_t            addr,
    input logic [PEND_CNT_W-1:0] cnt,
    input logic                  bulk
);
    vreg_pend_t v;
    int         size;
    int         base;
    v    = '0;
    size = bulk ? (1 << cnt) : 1;
    base = (int'(addr) / size) * size;
    for (int r = base; r < base + size; r++) begin
        v[r] = 1'b1;
    end
    return v;
endfunction

// a set of the same register in the same cycle wins over its clear
function automatic vreg_pend_t next_pend(
    input vreg_pend_t pend,
    input vreg_pend_t clr,
    input logic       set_en,
    input vreg_addr_t set_addr
);
    vreg_pend_t v;
    v = pend & ~clr;
    if (set_en) begin
        v[set_addr] = 1'b1;
    end
    return v;
endfunction

`endif

// ==== verif/vreg_wr_subsys_tb.sv ====
// testbench for the write-back subsystem at VREG_W = 64
// every task is entered and left at a rising clock edge

`timescale 1ns/100ps
`default_nettype none

module vreg_wr_subsys_tb;
    import vreg_pkg::*;

    localparam int VREG_W     = 64;
    localparam int WAIT_LIMIT = 50;

    `include "vreg_wr_ref.svh"

    logic                  clk_i;
    logic                  arst_n_i;
    logic                  pipe0_wr_valid_i;
    logic                  pipe0_wr_ready_o;
    logic                  pipe0_wr_clr_i;
    vreg_addr_t            pipe0_wr_addr_i;
    logic [VREG_W/8-1:0]   pipe0_wr_be_i;
    logic [VREG_W-1:0]     pipe0_wr_data_i;
    logic [PEND_CNT_W-1:0] pipe0_wr_clr_cnt_i;
    logic                  pipe1_wr_valid_i;
    logic                  pipe1_wr_ready_o;
    logic                  pipe1_wr_clr_i;
    vreg_addr_t            pipe1_wr_addr_i;
    logic [VREG_W/8-1:0]   pipe1_wr_be_i;
    logic [VREG_W-1:0]     pipe1_wr_data_i;
    logic [PEND_CNT_W-1:0] pipe1_wr_clr_cnt_i;
    logic                  pend_set_i;
    vreg_addr_t            pend_set_addr_i;
    vreg_addr_t            rd_addr_i;
    logic [VREG_W-1:0]     rd_data_o;
    vreg_pend_t            pend_vreg_o;

    // model of the register file, scoreboard and the two one-entry stages
    logic [VREG_W-1:0]     m_reg [VREG_CNT];
    vreg_pend_t            m_pend;
    logic [1:0]            m_valid;
    logic [1:0]            req_busy;
    vreg_addr_t            s_addr [2];
    logic [VREG_W/8-1:0]   s_be [2];
    logic [VREG_W-1:0]     s_data [2];
    logic                  s_clr [2];
    logic [PEND_CNT_W-1:0] s_cnt [2];
    logic [31:0]           lcg_state = 32'h76f6c979;

    vreg_wr_subsys #(.VREG_W(VREG_W)) vreg_wr_subsys_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // as in the stages a held request is written one edge after acceptance
    always @(posedge clk_i) begin : model_update
        vreg_pend_t clr;
        int         p;
        if (!arst_n_i) begin
            m_valid = 2'b00;
            m_pend  = '0;
        end else begin
            assert (pipe0_wr_ready_o === 1'b1) else fail_run($sformatf(
                "Mismatch at %0t: pipe0_wr_ready_o got %b expected 1", $time, pipe0_wr_ready_o));
            assert (pipe1_wr_ready_o === (!m_valid[1] || !m_valid[0])) else fail_run($sformatf(
                "Mismatch at %0t: pipe1_wr_ready_o got %b expected %b", $time,
                pipe1_wr_ready_o, !m_valid[1] || !m_valid[0]));
            clr = '0;
            if (m_valid != 2'b00) begin
                p = m_valid[0] ? 0 : 1;
                m_reg[s_addr[p]] = byte_merge(m_reg[s_addr[p]], s_data[p], s_be[p]);
                if (s_clr[p]) begin
                    clr = clear_vec(s_addr[p], s_cnt[p], p == 1);
                end
                m_valid[p] = 1'b0;
            end
            m_pend = next_pend(m_pend, clr, pend_set_i, pend_set_addr_i);
            if (pipe0_wr_valid_i && pipe0_wr_ready_o) begin
                m_valid[0] = 1'b1;
                s_addr[0]  = pipe0_wr_addr_i;
                s_be[0]    = pipe0_wr_be_i;
                s_data[0]  = pipe0_wr_data_i;
                s_clr[0]   = pipe0_wr_clr_i;
                s_cnt[0]   = pipe0_wr_clr_cnt_i;
            end
            if (pipe1_wr_valid_i && pipe1_wr_ready_o) begin
                m_valid[1] = 1'b1;
                s_addr[1]  = pipe1_wr_addr_i;
                s_be[1]    = pipe1_wr_be_i;
                s_data[1]  = pipe1_wr_data_i;
                s_clr[1]   = pipe1_wr_clr_i;
                s_cnt[1]   = pipe1_wr_clr_cnt_i;
            end
        end
    end

    task automatic load_req(input int p, input vreg_addr_t addr, input logic [VREG_W/8-1:0] be,
                            input logic [VREG_W-1:0] data, input logic clr,
                            input logic [PEND_CNT_W-1:0] cnt);
        if (p == 0) begin
            pipe0_wr_valid_i   <= 1'b1;
            pipe0_wr_addr_i    <= addr;
            pipe0_wr_be_i      <= be;
            pipe0_wr_data_i    <= data;
            pipe0_wr_clr_i     <= clr;
            pipe0_wr_clr_cnt_i <= cnt;
        end else begin
            pipe1_wr_valid_i   <= 1'b1;
            pipe1_wr_addr_i    <= addr;
            pipe1_wr_be_i      <= be;
            pipe1_wr_data_i    <= data;
            pipe1_wr_clr_i     <= clr;
            pipe1_wr_clr_cnt_i <= cnt;
        end
        req_busy[p] = 1'b1;
    endtask

    // waits at least one edge, so a pend set driven with the requests lasts one cycle
    task automatic push_requests();
        int n;
        n = 0;
        do begin
            @(posedge clk_i);
            pend_set_i <= 1'b0;
            if (req_busy[0] && pipe0_wr_ready_o) begin
                pipe0_wr_valid_i <= 1'b0;
                req_busy[0] = 1'b0;
            end
            if (req_busy[1] && pipe1_wr_ready_o) begin
                pipe1_wr_valid_i <= 1'b0;
                req_busy[1] = 1'b0;
            end
            n++;
        end while (req_busy != 2'b00 && n < WAIT_LIMIT);
        if (req_busy != 2'b00) begin
            fail_run("Timeout: a write request was not accepted");
        end
    endtask

    task automatic settle();
        int n;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (m_valid != 2'b00 && n < WAIT_LIMIT);
        if (m_valid != 2'b00) begin
            fail_run("Timeout: held write requests never reached the register file");
        end
        @(posedge clk_i);
    endtask

    task automatic set_pend(input vreg_addr_t addr);
        pend_set_i      <= 1'b1;
        pend_set_addr_i <= addr;
        @(posedge clk_i);
        pend_set_i      <= 1'b0;
    endtask

    task automatic read_check(input vreg_addr_t addr);
        rd_addr_i <= addr;
        @(posedge clk_i);
        @(negedge clk_i);
        assert (rd_data_o === m_reg[addr]) else fail_run($sformatf(
            "Mismatch at %0t: rd_data_o of register %0d got %h expected %h",
            $time, addr, rd_data_o, m_reg[addr]));
        @(posedge clk_i);
    endtask

    task automatic read_all();
        for (int a = 0; a < VREG_CNT; a++) begin
            read_check(vreg_addr_t'(a));
        end
    endtask

    task automatic check_pend();
        @(negedge clk_i);
        assert (pend_vreg_o === m_pend) else fail_run($sformatf(
            "Mismatch at %0t: pend_vreg_o got %h expected %h", $time, pend_vreg_o, m_pend));
        @(posedge clk_i);
    endtask

    initial begin : main_seq
        logic [31:0] r;
        logic [31:0] r2;
        int          issued;
        {arst_n_i, pipe0_wr_valid_i, pipe1_wr_valid_i, pend_set_i} = '0;
        {pipe0_wr_addr_i, pipe0_wr_be_i, pipe0_wr_data_i, pipe0_wr_clr_i} = '0;
        {pipe1_wr_addr_i, pipe1_wr_be_i, pipe1_wr_data_i, pipe1_wr_clr_i} = '0;
        {pipe0_wr_clr_cnt_i, pipe1_wr_clr_cnt_i, pend_set_addr_i, rd_addr_i} = '0;
        req_busy = 2'b00;
        repeat (16) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(posedge clk_i);

        // full writes of every register on pipeline 0, then a few on pipeline 1
        for (int a = 0; a < VREG_CNT; a++) begin
            load_req(0, vreg_addr_t'(a), '1, {next_rand(), next_rand()}, 1'b0, 2'd0);
            push_requests();
        end
        for (int a = 0; a < 4; a++) begin
            load_req(1, vreg_addr_t'(a * 8 + 2), '1, {next_rand(), next_rand()}, 1'b0, 2'd0);
            push_requests();
        end
        settle();
        read_all();

        load_req(0, 5'd5, 8'h0f, {next_rand(), next_rand()}, 1'b0, 2'd0);
        push_requests();
        load_req(1, 5'd9, 8'ha5, {next_rand(), next_rand()}, 1'b0, 2'd0);
        push_requests();
        settle();
        read_check(5'd5);
        read_check(5'd9);

        // same address from both pipelines in one cycle
        load_req(0, 5'd12, '1, {next_rand(), next_rand()}, 1'b0, 2'd0);
        load_req(1, 5'd12, '1, {next_rand(), next_rand()}, 1'b0, 2'd0);
        push_requests();
        settle();
        read_check(5'd12);

        set_pend(5'd3);
        set_pend(5'd4);
        set_pend(5'd7);
        set_pend(5'd20);
        check_pend();
        // pipeline 0 is single mode, so the clear count has no effect
        load_req(0, 5'd4, '1, {next_rand(), next_rand()}, 1'b1, 2'd3);
        push_requests();
        settle();
        check_pend();
        load_req(0, 5'd20, '1, {next_rand(), next_rand()}, 1'b1, 2'd0);
        push_requests();
        set_pend(5'd20);
        settle();
        check_pend();

        for (int a = 0; a < VREG_CNT; a++) begin
            set_pend(vreg_addr_t'(a));
        end
        for (int c = 0; c < 4; c++) begin
            load_req(1, vreg_addr_t'(c * 5 + 1), '1, {next_rand(), next_rand()}, 1'b1,
                     PEND_CNT_W'(c));
            push_requests();
            settle();
            check_pend();
        end

        issued = 0;
        while (issued < 200) begin
            r = next_rand();
            if (r[0]) begin
                load_req(0, r[12:8], r[23:16], {next_rand(), next_rand()}, r[2], r[5:4]);
                issued++;
            end
            if (r[1]) begin
                r2 = next_rand();
                load_req(1, r2[4:0], r2[15:8], {next_rand(), next_rand()}, r2[16], r2[21:20]);
                issued++;
            end
            pend_set_i      <= r[3];
            pend_set_addr_i <= r[28:24];
            push_requests();
        end
        settle();
        read_all();
        check_pend();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/vreg_wr_subsys.sv ====
// write-back subsystem with two pipelines sharing one register file write port
// pipeline 0 has priority and clears single registers while pipeline 1 clears aligned groups

`timescale 1ns/100ps
`default_nettype none

module vreg_wr_subsys #(
    parameter int unsigned VREG_W = 128
) (
    input  logic                            clk_i,
    input  logic                            arst_n_i,

    input  logic                            pipe0_wr_valid_i,
    output logic                            pipe0_wr_ready_o,
    input  vreg_pkg::vreg_addr_t            pipe0_wr_addr_i,
    input  logic [VREG_W/8-1:0]             pipe0_wr_be_i,
    input  logic [VREG_W-1:0]               pipe0_wr_data_i,
    input  logic                            pipe0_wr_clr_i,
    input  logic [vreg_pkg::PEND_CNT_W-1:0] pipe0_wr_clr_cnt_i,

    input  logic                            pipe1_wr_valid_i,
    output logic                            pipe1_wr_ready_o,
    input  vreg_pkg::vreg_addr_t            pipe1_wr_addr_i,
    input  logic [VREG_W/8-1:0]             pipe1_wr_be_i,
    input  logic [VREG_W-1:0]               pipe1_wr_data_i,
    input  logic                            pipe1_wr_clr_i,
    input  logic [vreg_pkg::PEND_CNT_W-1:0] pipe1_wr_clr_cnt_i,

    input  logic                            pend_set_i,
    input  vreg_pkg::vreg_addr_t            pend_set_addr_i,

    input  vreg_pkg::vreg_addr_t            rd_addr_i,
    output logic [VREG_W-1:0]               rd_data_o,

    output vreg_pkg::vreg_pend_t            pend_vreg_o
);
    import vreg_pkg::*;

    localparam int unsigned PIPE_CNT = 2;

    logic                vrf_wr_en;
    vreg_addr_t          vrf_wr_addr;
    logic [VREG_W/8-1:0] vrf_wr_be;
    logic [VREG_W-1:0]   vrf_wr_data;
    vreg_pend_t          pend_clr;

    vreg_wr_if #(.VREG_W(VREG_W)) pipe_req [PIPE_CNT] ();

    vreg_wr_stage #(
        .VREG_W(VREG_W)
    ) pipe0_stage_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .wr_valid_i  (pipe0_wr_valid_i),
        .wr_ready_o  (pipe0_wr_ready_o),
        .wr_addr_i   (pipe0_wr_addr_i),
        .wr_be_i     (pipe0_wr_be_i),
        .wr_data_i   (pipe0_wr_data_i),
        .wr_clr_i    (pipe0_wr_clr_i),
        .wr_clr_cnt_i(pipe0_wr_clr_cnt_i),
        .req         (pipe_req[0])
    );

    vreg_wr_stage #(
        .VREG_W(VREG_W)
    ) pipe1_stage_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .wr_valid_i  (pipe1_wr_valid_i),
        .wr_ready_o  (pipe1_wr_ready_o),
        .wr_addr_i   (pipe1_wr_addr_i),
        .wr_be_i     (pipe1_wr_be_i),
        .wr_data_i   (pipe1_wr_data_i),
        .wr_clr_i    (pipe1_wr_clr_i),
        .wr_clr_cnt_i(pipe1_wr_clr_cnt_i),
        .req         (pipe_req[1])
    );

    vreg_wr_mux #(
        .VREG_W       (VREG_W),
        .PIPE_CNT     (PIPE_CNT),
        .PIPE_CLR_MODE('{CLR_SINGLE, CLR_BULK})
    ) wr_mux_inst (
        .req          (pipe_req),
        .vrf_wr_en_o  (vrf_wr_en),
        .vrf_wr_addr_o(vrf_wr_addr),
        .vrf_wr_be_o  (vrf_wr_be),
        .vrf_wr_data_o(vrf_wr_data),
        .pend_clr_o   (pend_clr)
    );

    vregfile #(
        .VREG_W(VREG_W)
    ) vregfile_inst (
        .clk_i    (clk_i),
        .wr_en_i  (vrf_wr_en),
        .wr_addr_i(vrf_wr_addr),
        .wr_be_i  (vrf_wr_be),
        .wr_data_i(vrf_wr_data),
        .rd_addr_i(rd_addr_i),
        .rd_data_o(rd_data_o)
    );

    vreg_pend_tracker pend_tracker_inst (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .set_i     (pend_set_i),
        .set_addr_i(pend_set_addr_i),
        .clr_i     (pend_clr),
        .pend_o    (pend_vreg_o)
    );

endmodule

`default_nettype wire

// ==== rtl/vregfile.sv ====
// 32-entry vector register file with a byte-enabled write port and a registered read port
// contents are undefined after power-up
// a read of the entry being written returns the old data

`timescale 1ns/100ps
`default_nettype none

module vregfile #(
    parameter int unsigned VREG_W = 128
) (
    input  logic                 clk_i,

    input  logic                 wr_en_i,
    input  vreg_pkg::vreg_addr_t wr_addr_i,
    input  logic [VREG_W/8-1:0]  wr_be_i,
    input  logic [VREG_W-1:0]    wr_data_i,

    input  vreg_pkg::vreg_addr_t rd_addr_i,
    output logic [VREG_W-1:0]    rd_data_o
);
    import vreg_pkg::*;

    logic [VREG_W-1:0] mem [VREG_CNT];

    // only the enabled bytes of the entry are updated
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            for (int b = 0; b < VREG_W / 8; b++) begin
                if (wr_be_i[b]) begin
                    mem[wr_addr_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

// ==== rtl/vreg_pend_tracker.sv ====
// pending-write scoreboard with one bit per vector register
// a set wins over a clear of the same register in the same cycle

`timescale 1ns/100ps
`default_nettype none

module vreg_pend_tracker (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    input  logic                 set_i,
    input  vreg_pkg::vreg_addr_t set_addr_i,
    input  vreg_pkg::vreg_pend_t clr_i,

    output vreg_pkg::vreg_pend_t pend_o
);
    import vreg_pkg::*;

    vreg_pend_t pend_q;
    vreg_pend_t set_vec;

    always_comb begin
        set_vec = '0;
        if (set_i) begin
            set_vec[set_addr_i] = 1'b1;
        end
    end

    // clear first and then set
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_q <= '0;
        end else begin
            pend_q <= (pend_q & ~clr_i) | set_vec;
        end
    end

    assign pend_o = pend_q;

endmodule

`default_nettype wire

// ==== rtl/vreg_wr_mux.sv ====
// fixed-priority write mux onto the one register file write port with pipeline 0 highest
// purely combinational logic that drives the write port fields to zero when idle

`timescale 1ns/100ps
`default_nettype none

module vreg_wr_mux #(
    parameter int unsigned        VREG_W                  = 128,
    parameter int unsigned        PIPE_CNT                = 2,
    parameter vreg_pkg::clr_mode_e PIPE_CLR_MODE [PIPE_CNT] = '{default: vreg_pkg::CLR_SINGLE}
) (
    vreg_wr_if.dst                 req [PIPE_CNT],

    output logic                   vrf_wr_en_o,
    output vreg_pkg::vreg_addr_t   vrf_wr_addr_o,
    output logic [VREG_W/8-1:0]    vrf_wr_be_o,
    output logic [VREG_W-1:0]      vrf_wr_data_o,
    output vreg_pkg::vreg_pend_t   pend_clr_o
);
    import vreg_pkg::*;

    logic [PIPE_CNT-1:0]                 valid;
    logic [PIPE_CNT-1:0]                 ready;
    vreg_addr_t                          addr    [PIPE_CNT];
    logic [PIPE_CNT-1:0][VREG_W/8-1:0]   be;
    logic [PIPE_CNT-1:0][VREG_W-1:0]     data;
    logic [PIPE_CNT-1:0]                 clr;
    logic [PIPE_CNT-1:0][PEND_CNT_W-1:0] clr_cnt;
    vreg_pend_t                          pipe_clr [PIPE_CNT];

    for (genvar i = 0; i < PIPE_CNT; i++) begin : g_pipe
        vreg_addr_t addr_mask;

        assign valid[i]     = req[i].valid;
        assign addr[i]      = req[i].addr;
        assign be[i]        = req[i].be;
        assign data[i]      = req[i].data;
        assign clr[i]       = req[i].clr;
        assign clr_cnt[i]   = req[i].clr_cnt;
        assign req[i].ready = ready[i];

        // bulk mode ignores the low clr_cnt address bits, giving an aligned group
        assign addr_mask = {VADDR_W{1'b1}} << clr_cnt[i];

        always_comb begin
            pipe_clr[i] = '0;
            if (valid[i] && ready[i] && clr[i]) begin
                if (PIPE_CLR_MODE[i] == CLR_BULK) begin
                    for (int r = 0; r < VREG_CNT; r++) begin
                        pipe_clr[i][r] = (vreg_addr_t'(r) & addr_mask) == (addr[i] & addr_mask);
                    end
                end else begin
                    pipe_clr[i][addr[i]] = 1'b1;
                end
            end
        end
    end

    // a pipeline is stalled whenever any lower-index pipeline is valid
    always_comb begin
        for (int i = 0; i < PIPE_CNT; i++) begin
            ready[i] = 1'b1;
            for (int j = 0; j < i; j++) begin
                if (valid[j]) begin
                    ready[i] = 1'b0;
                end
            end
        end
    end

    // walking down from the highest index leaves the lowest valid pipeline selected
    always_comb begin
        vrf_wr_en_o   = 1'b0;
        vrf_wr_addr_o = '0;
        vrf_wr_be_o   = '0;
        vrf_wr_data_o = '0;
        for (int i = PIPE_CNT - 1; i >= 0; i--) begin
            if (valid[i]) begin
                vrf_wr_en_o   = 1'b1;
                vrf_wr_addr_o = addr[i];
                vrf_wr_be_o   = be[i];
                vrf_wr_data_o = data[i];
            end
        end
    end

    always_comb begin
        pend_clr_o = '0;
        for (int i = 0; i < PIPE_CNT; i++) begin
            pend_clr_o |= pipe_clr[i];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/vreg_wr_stage.sv ====
// one-entry request register in front of the write mux
// wr_ready_o is combinational from the mux grant, wr_valid_i must not depend on it

`timescale 1ns/100ps
`default_nettype none

module vreg_wr_stage #(
    parameter int unsigned VREG_W = 128
) (
    input  logic                            clk_i,
    input  logic                            arst_n_i,

    input  logic                            wr_valid_i,
    output logic                            wr_ready_o,
    input  vreg_pkg::vreg_addr_t            wr_addr_i,
    input  logic [VREG_W/8-1:0]             wr_be_i,
    input  logic [VREG_W-1:0]               wr_data_i,
    input  logic                            wr_clr_i,
    input  logic [vreg_pkg::PEND_CNT_W-1:0] wr_clr_cnt_i,

    vreg_wr_if.src                          req
);
    import vreg_pkg::*;

    logic                  valid_q;
    vreg_addr_t            addr_q;
    logic [VREG_W/8-1:0]   be_q;
    logic [VREG_W-1:0]     data_q;
    logic                  clr_q;
    logic [PEND_CNT_W-1:0] clr_cnt_q;
    logic                  accept;

    // a granted entry can be refilled in the same cycle
    assign wr_ready_o = ~valid_q | req.ready;
    assign accept     = wr_valid_i & wr_ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (req.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q    <= wr_addr_i;
            be_q      <= wr_be_i;
            data_q    <= wr_data_i;
            clr_q     <= wr_clr_i;
            clr_cnt_q <= wr_clr_cnt_i;
        end
    end

    assign req.valid   = valid_q;
    assign req.addr    = addr_q;
    assign req.be      = be_q;
    assign req.data    = data_q;
    assign req.clr     = clr_q;
    assign req.clr_cnt = clr_cnt_q;

endmodule

`default_nettype wire

// ==== rtl/vreg_wr_if.sv ====
// one register write request between a request register and the write mux
// ready is a grant that consumes the held request at an edge where valid is also high

`timescale 1ns/100ps
`default_nettype none

interface vreg_wr_if #(
    parameter int unsigned VREG_W = 128
);
    import vreg_pkg::*;

    logic                  valid;
    logic                  ready;
    vreg_addr_t            addr;
    logic [VREG_W/8-1:0]   be;
    logic [VREG_W-1:0]     data;
    logic                  clr;
    logic [PEND_CNT_W-1:0] clr_cnt;

    modport src (
        output valid, addr, be, data, clr, clr_cnt,
        input  ready
    );

    modport dst (
        input  valid, addr, be, data, clr, clr_cnt,
        output ready
    );

endinterface

`default_nettype wire

// ==== rtl/vreg_pkg.sv ====
// shared widths and types for the vector register write-back path

`default_nettype none

package vreg_pkg;

    // register address width
    localparam int unsigned VADDR_W = 5;

    // number of vector registers
    localparam int unsigned VREG_CNT = 32;

    // the clear count lets a bulk clear span at most 8 registers (a quarter of the file)
    localparam int unsigned PEND_CNT_W = 2;

    typedef logic [VADDR_W-1:0] vreg_addr_t;

    // one bit per register
    typedef logic [VREG_CNT-1:0] vreg_pend_t;

    // how a pipeline clears pending bits on a granted write
    // single clears one register, bulk clears an aligned group of 2**clr_cnt registers
    typedef enum logic {
        CLR_SINGLE,
        CLR_BULK
    } clr_mode_e;

endpackage

`default_nettype wire
